/* ui_tester.f */
logic/ui_pkg.sv
logic/ui_apb_regs.sv
logic/ui_write_gen.sv
logic/ui_read_check.sv
logic/ui_arbiter.sv
logic/ui_tester_top.sv
test/ui_mem_model.sv
test/tb_ui_tester.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ui_tester \
    -f ui_tester.f -o sim_ui_tester > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ui_tester > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* test/tb_ui_tester.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ui_tester import ui_pkg::*; ();

    logic       ui_clk;
    logic       rst;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    ui_cmd_t    ui_cmd;
    ui_rsp_t    ui_rsp;
    logic [6:0] stall_pct;
    int         errors       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         cycles       = 0;
    // Grows by 200 for every burst programmed
    int         cycle_limit  = 2000;

    ui_tester_top u_dut (
        .ui_clk  (ui_clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .ui_cmd  (ui_cmd),
        .ui_rsp  (ui_rsp)
    );

    ui_mem_model u_mem (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .stall_pct (stall_pct),
        .ui_cmd    (ui_cmd),
        .ui_rsp    (ui_rsp)
    );

    initial begin
        ui_clk = 1'b0;
        forever #2 ui_clk = ~ui_clk;
    end

    always @(posedge ui_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped, the tests did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [ADDR_W-1:0] burst_addr(input logic [ADDR_W-1:0] base,
                                                     input int i);
        return base + ADDR_W'(i * BURST_STEP);
    endfunction

    // Lane k of the burst at A holds seed ^ (A + k)
    function automatic logic [DATA_W-1:0] expected_burst(input logic [31:0] seed,
                                                         input logic [ADDR_W-1:0] addr);
        logic [31:0] a;
        a = 32'(addr);
        return {seed ^ (a + 32'd3), seed ^ (a + 32'd2), seed ^ (a + 32'd1), seed ^ a};
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////
    task automatic write_reg(input logic [7:0] off, input logic [31:0] data, input logic err_exp);
        @(negedge ui_clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: off, pwdata: data};
        @(negedge ui_clk);
        apb_req.penable = 1'b1;
        #1;
        if (apb_rsp.pready !== 1'b1) begin
            $display("error at %0t ns: pready low on write to %0h", $time, off);
            errors++;
        end
        if (apb_rsp.pslverr !== err_exp) begin
            $display("error at %0t ns: pslverr %0b on write to %0h", $time, apb_rsp.pslverr, off);
            errors++;
        end
        @(negedge ui_clk);
        apb_req = '0;
    endtask

    task automatic read_reg(input logic [7:0] off, output logic [31:0] data, input logic err_exp);
        @(negedge ui_clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: off, pwdata: 32'd0};
        @(negedge ui_clk);
        apb_req.penable = 1'b1;
        #1;
        data = apb_rsp.prdata;
        if (apb_rsp.pready !== 1'b1) begin
            $display("error at %0t ns: pready low on read of %0h", $time, off);
            errors++;
        end
        if (apb_rsp.pslverr !== err_exp) begin
            $display("error at %0t ns: pslverr %0b on read of %0h", $time, apb_rsp.pslverr, off);
            errors++;
        end
        @(negedge ui_clk);
        apb_req = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // Job helpers
    ////////////////////////////////////////////////////////////
    task automatic start_job(input logic [ADDR_W-1:0] base, input int count,
                             input logic [31:0] seed);
        cycle_limit += 200 * count;
        write_reg(REG_BASE, 32'(base), 1'b0);
        write_reg(REG_COUNT, 32'(count), 1'b0);
        write_reg(REG_SEED, seed, 1'b0);
        write_reg(REG_CTRL, 32'd1, 1'b0);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (st[1] == 1'b0) begin
            read_reg(REG_STATUS, st, 1'b0);
        end
    endtask

    task automatic check_job(input logic [ADDR_W-1:0] base, input int count,
                             input logic [31:0] seed, input int wr0, input int rd0);
        logic [31:0]       rd;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] first;
        int                faults;
        faults = 0;
        first  = '0;
        for (int i = 0; i < count; i++) begin
            a = burst_addr(base, i);
            if (u_mem.fault.exists(a)) begin
                if (faults == 0) begin
                    first = a;
                end
                faults++;
            end
            if (!u_mem.mem.exists(a)) begin
                $display("No write ever reached address %0h", a);
                errors++;
            end else if (u_mem.mem[a] !== expected_burst(seed, a)) begin
                $display("error at %0t ns: memory at %0h is %0h, expected %0h",
                         $time, a, u_mem.mem[a], expected_burst(seed, a));
                errors++;
            end
        end
        read_reg(REG_STATUS, rd, 1'b0);
        check_val("status", rd, 32'h2);
        read_reg(REG_ERRORS, rd, 1'b0);
        check_val("error count", rd, 32'(faults));
        if (faults > 0) begin
            read_reg(REG_FIRST_ERR, rd, 1'b0);
            check_val("first error address", rd, 32'(first));
        end
        check_val("writes seen", 32'(u_mem.wr_seen - wr0), 32'(count));
        check_val("reads seen", 32'(u_mem.rd_seen - rd0), 32'(count));
    endtask

    task automatic run_job(input logic [ADDR_W-1:0] base, input int count,
                           input logic [31:0] seed);
        int wr0;
        int rd0;
        wr0 = u_mem.wr_seen;
        rd0 = u_mem.rd_seen;
        start_job(base, count, seed);
        wait_done();
        check_job(base, count, seed, wr0, rd0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d checks failed", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    initial begin
        int                errs0;
        int                cnt;
        int                nf;
        int                wr0;
        int                rd0;
        logic [ADDR_W-1:0] base;
        logic [31:0]       seed;
        logic [31:0]       rd;
        rst       = 1'b1;
        apb_req   = '0;
        stall_pct = 7'd20;
        void'($urandom(20269));
        repeat (16) @(negedge ui_clk);
        rst = 1'b0;

        errs0 = errors;
        base  = ADDR_W'($urandom);
        cnt   = int'($urandom_range(65535));
        seed  = $urandom;
        write_reg(REG_BASE, 32'(base), 1'b0);
        write_reg(REG_COUNT, 32'(cnt), 1'b0);
        write_reg(REG_SEED, seed, 1'b0);
        read_reg(REG_BASE, rd, 1'b0);
        check_val("base", rd, 32'(base));
        read_reg(REG_COUNT, rd, 1'b0);
        check_val("count", rd, 32'(cnt));
        read_reg(REG_SEED, rd, 1'b0);
        check_val("seed", rd, seed);
        read_reg(8'h20, rd, 1'b1);
        write_reg(REG_STATUS, 32'h3, 1'b1);
        finish_test("registers", errs0);

        errs0 = errors;
        for (int j = 0; j < 5; j++) begin
            run_job(ADDR_W'($urandom), 1 + int'($urandom_range(63)), $urandom);
        end
        finish_test("clean jobs", errs0);

        // Corrupt a few bursts inside the job range
        errs0 = errors;
        base  = ADDR_W'($urandom);
        cnt   = 16 + int'($urandom_range(48));
        nf    = 1 + int'($urandom_range(3));
        for (int f = 0; f < nf; f++) begin
            u_mem.fault[burst_addr(base, int'($urandom_range(cnt - 1)))] = 1'b1;
        end
        run_job(base, cnt, $urandom);
        u_mem.fault.delete();
        finish_test("fault detection", errs0);

        errs0     = errors;
        stall_pct = 7'd70;
        for (int j = 0; j < 5; j++) begin
            run_job(ADDR_W'($urandom), 1 + int'($urandom_range(63)), $urandom);
        end
        finish_test("heavy back-pressure", errs0);

        // Second start arrives with a new setup while the first job runs
        errs0     = errors;
        stall_pct = 7'd50;
        base      = ADDR_W'($urandom);
        seed      = $urandom;
        wr0       = u_mem.wr_seen;
        rd0       = u_mem.rd_seen;
        start_job(base, 64, seed);
        read_reg(REG_STATUS, rd, 1'b0);
        check_val("status while busy", rd, 32'h1);
        write_reg(REG_COUNT, 32'd3, 1'b0);
        write_reg(REG_SEED, ~seed, 1'b0);
        write_reg(REG_CTRL, 32'd1, 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_val("status after second start", rd, 32'h1);
        wait_done();
        check_job(base, 64, seed, wr0, rd0);
        repeat (50) @(negedge ui_clk);
        check_val("writes after idle", 32'(u_mem.wr_seen - wr0), 32'd64);
        finish_test("start while busy", errs0);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/ui_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_mem_model import ui_pkg::*; (
    input  wire logic       ui_clk,
    input  wire logic       rst,
    input  wire logic [6:0] stall_pct,
    input  wire ui_cmd_t    ui_cmd,
    output ui_rsp_t         ui_rsp
);

    // Sparse backing store, and addresses whose read data comes back corrupted
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    bit                fault [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] ret_data [$];
    int                ret_due [$];
    int                cyc      = 0;
    int                last_due = 0;
    int                wr_seen  = 0;
    int                rd_seen  = 0;

    initial begin
        ui_rsp = '0;
    end

    ////////////////////////////////////////////////////////////
    // Command acceptance
    ////////////////////////////////////////////////////////////
    always @(posedge ui_clk) begin
        logic [DATA_W-1:0] d;
        int                due;
        if (rst) begin
            ret_data.delete();
            ret_due.delete();
        end else if (ui_cmd.en && ui_rsp.rdy) begin
            if (ui_cmd.cmd == CMD_WRITE && ui_cmd.wdf_wren && ui_cmd.wdf_end &&
                ui_rsp.wdf_rdy) begin
                mem[ui_cmd.addr] = ui_cmd.wdf_data;
                wr_seen++;
            end else if (ui_cmd.cmd == CMD_READ) begin
                d = mem.exists(ui_cmd.addr) ? mem[ui_cmd.addr] : '0;
                if (fault.exists(ui_cmd.addr)) begin
                    d = ~d;
                end
                // Never returns ahead of the read before it
                due = cyc + 2 + int'($urandom_range(8));
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                ret_data.push_back(d);
                ret_due.push_back(due);
                rd_seen++;
            end
        end
        cyc++;
    end

    ////////////////////////////////////////////////////////////
    // Ready stalls and read return
    ////////////////////////////////////////////////////////////
    always @(negedge ui_clk) begin
        if (rst) begin
            ui_rsp = '0;
        end else begin
            ui_rsp.rdy     = ($urandom_range(99) >= 32'(stall_pct));
            ui_rsp.wdf_rdy = ($urandom_range(99) >= 32'(stall_pct));
            if (ret_due.size() > 0 && ret_due[0] <= cyc) begin
                ui_rsp.rd_data_valid = 1'b1;
                ui_rsp.rd_data       = ret_data.pop_front();
                void'(ret_due.pop_front());
            end else begin
                ui_rsp.rd_data_valid = 1'b0;
                ui_rsp.rd_data       = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ui_tester_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_tester_top import ui_pkg::*; (
    input  wire logic     ui_clk,
    input  wire logic     rst,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output ui_cmd_t       ui_cmd,
    input  wire ui_rsp_t  ui_rsp
);

    job_cfg_t          cfg;
    logic              start;
    logic              job_done;
    logic [15:0]       error_count;
    logic [ADDR_W-1:0] first_err_addr;
    logic [15:0]       written;
    ui_req_t           wr_req;
    ui_req_t           rd_req;
    logic              wr_grant;
    logic              rd_grant;

    ////////////////////////////////////////////////////////////
    // Software-facing registers
    ////////////////////////////////////////////////////////////
    ui_apb_regs u_regs (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .cfg            (cfg),
        .start          (start),
        .job_done       (job_done),
        .error_count    (error_count),
        .first_err_addr (first_err_addr)
    );

    ui_write_gen u_write_gen (
        .ui_clk  (ui_clk),
        .rst     (rst),
        .cfg     (cfg),
        .start   (start),
        .req     (wr_req),
        .grant   (wr_grant),
        .written (written)
    );

    // Up to eight reads in flight
    ui_read_check #(
        .RD_DEPTH (8)
    ) u_read_check (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .cfg            (cfg),
        .start          (start),
        .written        (written),
        .req            (rd_req),
        .grant          (rd_grant),
        .rsp            (ui_rsp),
        .job_done       (job_done),
        .error_count    (error_count),
        .first_err_addr (first_err_addr)
    );

    ui_arbiter u_arbiter (
        .ui_clk   (ui_clk),
        .rst      (rst),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .wr_grant (wr_grant),
        .rd_grant (rd_grant),
        .ui_cmd   (ui_cmd),
        .ui_rsp   (ui_rsp)
    );

endmodule

`default_nettype wire

/* logic/ui_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_arbiter import ui_pkg::*; (
    input  wire logic    ui_clk,
    input  wire logic    rst,
    input  wire ui_req_t wr_req,
    input  wire ui_req_t rd_req,
    output logic         wr_grant,
    output logic         rd_grant,
    output ui_cmd_t      ui_cmd,
    input  wire ui_rsp_t ui_rsp
);

    logic    last_rd_q;
    logic    wr_ok;
    logic    rd_ok;
    logic    pick_rd;
    ui_req_t sel;

    // Writes also need room in the write-data FIFO
    function automatic logic eligible(input ui_req_t r, input ui_rsp_t s);
        logic ok;
        ok = r.valid & s.rdy;
        if (r.cmd == CMD_WRITE) begin
            ok = ok & s.wdf_rdy;
        end
        return ok;
    endfunction

    ////////////////////////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////////////////////////
    assign wr_ok   = eligible(wr_req, ui_rsp);
    assign rd_ok   = eligible(rd_req, ui_rsp);
    // On a tie the side that lost last time goes first
    assign pick_rd = rd_ok & (~wr_ok | ~last_rd_q);

    assign rd_grant = pick_rd;
    assign wr_grant = wr_ok & ~pick_rd;

    assign sel = pick_rd ? rd_req : wr_req;

    always_comb begin
        ui_cmd.en       = wr_grant | rd_grant;
        ui_cmd.cmd      = sel.cmd;
        ui_cmd.addr     = sel.addr;
        ui_cmd.wdf_data = sel.data;
        // Single-beat burst, data goes with the command
        ui_cmd.wdf_wren = ui_cmd.en & (sel.cmd == CMD_WRITE);
        ui_cmd.wdf_end  = ui_cmd.en & (sel.cmd == CMD_WRITE);
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            last_rd_q <= 1'b0;
        end else if (wr_grant || rd_grant) begin
            last_rd_q <= rd_grant;
        end
    end

endmodule

`default_nettype wire

/* logic/ui_read_check.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_read_check import ui_pkg::*; #(
    parameter int RD_DEPTH = 8
) (
    input  wire logic              ui_clk,
    input  wire logic              rst,
    input  wire job_cfg_t          cfg,
    input  wire logic              start,
    input  wire logic [15:0]       written,
    output ui_req_t                req,
    input  wire logic              grant,
    input  wire ui_rsp_t           rsp,
    output logic                   job_done,
    output logic [15:0]            error_count,
    output logic [ADDR_W-1:0]      first_err_addr
);

    localparam int PTR_W = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
    localparam int CNT_W = $clog2(RD_DEPTH + 1);

    job_cfg_t          job_q;
    logic              run_q;
    logic [15:0]       issued_q;
    logic [15:0]       compared_q;
    logic [CNT_W-1:0]  pending_q;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [ADDR_W-1:0] addr_fifo [RD_DEPTH];
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] exp_addr;
    logic              ret;
    logic              mismatch;

    assign rd_addr  = job_q.base + ADDR_W'(issued_q) * ADDR_W'(BURST_STEP);
    assign exp_addr = addr_fifo[rd_ptr];
    assign ret      = run_q & rsp.rd_data_valid;
    assign mismatch = rsp.rd_data != ui_pattern(job_q.seed, exp_addr);
    assign job_done = ret & (compared_q == job_q.count - 16'd1);

    // Only read what the writer has already had accepted
    always_comb begin
        req.valid = run_q & (written > issued_q) & (pending_q != CNT_W'(RD_DEPTH));
        req.cmd   = CMD_READ;
        req.addr  = rd_addr;
        req.data  = '0;
    end

    ////////////////////////////////////////////////////////////
    // Issue, in-flight tracking and compare
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk) begin
        if (rst || start) begin
            run_q          <= start & (cfg.count != 16'd0);
            issued_q       <= '0;
            compared_q     <= '0;
            pending_q      <= '0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            error_count    <= '0;
            first_err_addr <= '0;
        end else begin
            if (grant) begin
                issued_q <= issued_q + 16'd1;
                wr_ptr   <= (wr_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (ret) begin
                compared_q <= compared_q + 16'd1;
                rd_ptr     <= (rd_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                if (mismatch) begin
                    error_count <= error_count + 16'd1;
                    // Returns come back in issue order, so the first is the lowest index
                    if (error_count == 16'd0) begin
                        first_err_addr <= exp_addr;
                    end
                end
            end
            if (grant && !ret) begin
                pending_q <= pending_q + 1'b1;
            end else if (ret && !grant) begin
                pending_q <= pending_q - 1'b1;
            end
            if (job_done) begin
                run_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (start) begin
            job_q <= cfg;
        end
        if (grant) begin
            addr_fifo[wr_ptr] <= rd_addr;
        end
    end

endmodule

`default_nettype wire

/* logic/ui_write_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_write_gen import ui_pkg::*; (
    input  wire logic        ui_clk,
    input  wire logic        rst,
    input  wire job_cfg_t    cfg,
    input  wire logic        start,
    output ui_req_t          req,
    input  wire logic        grant,
    output logic [15:0]      written
);

    job_cfg_t          job_q;
    logic              valid_q;
    logic [15:0]       written_q;
    logic [ADDR_W-1:0] burst_addr;

    // Burst index equals the number already granted
    assign burst_addr = job_q.base + ADDR_W'(written_q) * ADDR_W'(BURST_STEP);

    always_comb begin
        req.valid = valid_q;
        req.cmd   = CMD_WRITE;
        req.addr  = burst_addr;
        req.data  = ui_pattern(job_q.seed, burst_addr);
    end

    assign written = written_q;

    ////////////////////////////////////////////////////////////
    // Burst sequencing
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            written_q <= '0;
        end else if (start) begin
            written_q <= '0;
            valid_q   <= (cfg.count != 16'd0);
        end else if (grant) begin
            written_q <= written_q + 16'd1;
            // Drop the request once the last burst is taken
            if (written_q + 16'd1 == job_q.count) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Job snapshot, so later register writes do not disturb a running job
    always_ff @(posedge ui_clk) begin
        if (start) begin
            job_q <= cfg;
        end
    end

endmodule

`default_nettype wire

/* logic/ui_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ui_apb_regs import ui_pkg::*; (
    input  wire logic              ui_clk,
    input  wire logic              rst,
    input  wire apb_req_t          apb_req,
    output apb_rsp_t               apb_rsp,
    output job_cfg_t               cfg,
    output logic                   start,
    input  wire logic              job_done,
    input  wire logic [15:0]       error_count,
    input  wire logic [ADDR_W-1:0] first_err_addr
);

    job_cfg_t    cfg_q;
    logic        busy_q;
    logic        done_q;
    logic        access;
    logic        reg_mapped;
    logic        reg_ro;
    logic        bad_access;
    logic        wr_ok;
    logic [31:0] rdata;

    // Second phase of a transfer
    assign access     = apb_req.psel & apb_req.penable;
    assign bad_access = ~reg_mapped | (apb_req.pwrite & reg_ro);
    assign wr_ok      = access & apb_req.pwrite & ~bad_access;

    ////////////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        reg_mapped = 1'b1;
        reg_ro     = 1'b0;
        rdata      = '0;
        case (apb_req.paddr)
            REG_CTRL:  rdata = '0;
            REG_BASE:  rdata = 32'(cfg_q.base);
            REG_COUNT: rdata = 32'(cfg_q.count);
            REG_SEED:  rdata = cfg_q.seed;
            REG_STATUS: begin
                rdata  = {30'b0, done_q, busy_q};
                reg_ro = 1'b1;
            end
            REG_ERRORS: begin
                rdata  = 32'(error_count);
                reg_ro = 1'b1;
            end
            REG_FIRST_ERR: begin
                rdata  = 32'(first_err_addr);
                reg_ro = 1'b1;
            end
            default: reg_mapped = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & bad_access;

    // A start while a job runs is dropped quietly
    assign start = wr_ok & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0] & ~busy_q;
    assign cfg   = cfg_q;

    ////////////////////////////////////////////////////////////
    // Configuration and job status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk) begin
        if (rst) begin
            cfg_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (wr_ok) begin
                case (apb_req.paddr)
                    REG_BASE:  cfg_q.base  <= apb_req.pwdata[ADDR_W-1:0];
                    REG_COUNT: cfg_q.count <= apb_req.pwdata[15:0];
                    REG_SEED:  cfg_q.seed  <= apb_req.pwdata;
                    default: ;
                endcase
            end
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (job_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ui_pkg.sv */
`default_nettype none

package ui_pkg;

    ////////////////////////////////////////////////////////////
    // Controller user-interface geometry
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W     = 27;
    localparam int DATA_W     = 128;
    localparam int BURST_STEP = 8;
    localparam int LANES      = DATA_W / 32;

    localparam logic [2:0] CMD_WRITE = 3'd0;
    localparam logic [2:0] CMD_READ  = 3'd1;

    // Register map, byte offsets on the APB side
    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_BASE      = 8'h04;
    localparam logic [7:0] REG_COUNT     = 8'h08;
    localparam logic [7:0] REG_SEED      = 8'h0C;
    localparam logic [7:0] REG_STATUS    = 8'h10;
    localparam logic [7:0] REG_ERRORS    = 8'h14;
    localparam logic [7:0] REG_FIRST_ERR = 8'h18;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              valid;
        logic [2:0]        cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } ui_req_t;

    typedef struct packed {
        logic              en;
        logic [2:0]        cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdf_data;
        logic              wdf_wren;
        logic              wdf_end;
    } ui_cmd_t;

    typedef struct packed {
        logic              rdy;
        logic              wdf_rdy;
        logic [DATA_W-1:0] rd_data;
        logic              rd_data_valid;
    } ui_rsp_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [15:0]       count;
        logic [31:0]       seed;
    } job_cfg_t;

    // Burst payload for address A: lane k is seed ^ (A + k), lane 0 in the low bits
    function automatic logic [DATA_W-1:0] ui_pattern(input logic [31:0] seed,
                                                     input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        word = '0;
        for (int k = 0; k < LANES; k++) begin
            word[32*k +: 32] = seed ^ (32'(addr) + 32'(k));
        end
        return word;
    endfunction

endpackage

`default_nettype wire
